// ==== common/w0rm_pkg.sv ====
`default_nettype none

package w0rm_pkg;

  // Core widths
  localparam int XLEN     = 32;
  localparam int INST_W   = 16;
  localparam int NUM_REGS = 16;
  localparam int REG_AW   = 4;

  typedef logic [REG_AW-1:0] reg_addr_t;
  typedef logic [XLEN-1:0]   data_t;
  typedef logic [INST_W-1:0] inst_t;

  // Opcode in bits 15..12
  // Codes above OP_STR decode as OP_NOP
  typedef enum logic [3:0] {
    OP_NOP  = 4'd0,
    OP_ADD  = 4'd1,
    OP_SUB  = 4'd2,
    OP_AND  = 4'd3,
    OP_OR   = 4'd4,
    OP_XOR  = 4'd5,
    OP_SHL  = 4'd6,
    OP_SHR  = 4'd7,
    OP_MOVI = 4'd8,
    OP_LDR  = 4'd9,
    OP_STR  = 4'd10
  } opcode_e;

  // Decode to execute
  typedef struct packed {
    opcode_e   op;
    reg_addr_t rd;
    data_t     rn_val;
    data_t     rm_val;
    data_t     rd_val;
    logic [7:0] imm8;
  } decoded_t;

  // Execute to memory / write-back
  typedef struct packed {
    opcode_e   op;
    reg_addr_t rd;
    data_t     result;
    data_t     addr;
    data_t     store_data;
  } exec_t;

  typedef enum logic {
    REQUEST     = 1'b0,
    WAIT_RETIRE = 1'b1
  } fetch_state_e;

  typedef enum logic {
    IDLE     = 1'b0,
    BUS_WAIT = 1'b1
  } mem_state_e;

endpackage

`default_nettype wire

// ==== fetch/inst_fetch.sv ====
`default_nettype none

module inst_fetch
  import w0rm_pkg::*;
#(
  parameter data_t RESET_PC = '0
)(
  input  wire   core_clk,
  input  wire   arst_n_i,
  input  wire   retire_i,
  output data_t inst_addr_o,
  output logic  inst_valid_o,
  input  inst_t inst_data_i,
  input  wire   inst_valid_i,
  output logic  fetch_valid_o,
  output inst_t fetch_inst_o
);

  fetch_state_e state_q;
  data_t        pc_q;
  logic         req_q;

  // The PC drives the address and stays stable while the request is up
  assign inst_addr_o  = pc_q;
  assign inst_valid_o = req_q;

  always_ff @(posedge core_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      state_q       <= REQUEST;
      pc_q          <= RESET_PC;
      req_q         <= 1'b0;
      fetch_valid_o <= 1'b0;
      fetch_inst_o  <= '0;
    end
    else
    begin
      fetch_valid_o <= 1'b0;
      case (state_q)
        REQUEST:
        begin
          // First request after reset release
          if (!req_q)
          begin
            req_q <= 1'b1;
          end
          else if (inst_valid_i)
          begin
            req_q         <= 1'b0;
            fetch_inst_o  <= inst_data_i;
            fetch_valid_o <= 1'b1;
            state_q       <= WAIT_RETIRE;
          end
        end
        WAIT_RETIRE:
        begin
          if (retire_i)
          begin
            pc_q    <= pc_q + data_t'(2);
            req_q   <= 1'b1;
            state_q <= REQUEST;
          end
        end
        default:
        begin
          state_q <= REQUEST;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== core/instr_decode.sv ====
`default_nettype none

module instr_decode
  import w0rm_pkg::*;
(
  input  wire       core_clk,
  input  wire       arst_n_i,
  input  wire       fetch_valid_i,
  input  inst_t     fetch_inst_i,
  output reg_addr_t rd_addr_o,
  output reg_addr_t rn_addr_o,
  output reg_addr_t rm_addr_o,
  input  data_t     rd_val_i,
  input  data_t     rn_val_i,
  input  data_t     rm_val_i,
  output logic      dec_valid_o,
  output decoded_t  dec_o
);

  opcode_e  op;
  decoded_t dec_d;

  // Register fields
  assign rd_addr_o = fetch_inst_i[11:8];
  assign rn_addr_o = fetch_inst_i[7:4];
  assign rm_addr_o = fetch_inst_i[3:0];

  always_comb
  begin
    if (fetch_inst_i[15:12] > OP_STR)
    begin
      op = OP_NOP;
    end
    else
    begin
      op = opcode_e'(fetch_inst_i[15:12]);
    end
  end

  always_comb
  begin
    dec_d.op     = op;
    dec_d.rd     = rd_addr_o;
    dec_d.rn_val = rn_val_i;
    dec_d.rm_val = rm_val_i;
    dec_d.rd_val = rd_val_i;
    dec_d.imm8   = fetch_inst_i[7:0];
  end

  always_ff @(posedge core_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      dec_valid_o <= 1'b0;
      dec_o       <= '0;
    end
    else
    begin
      dec_valid_o <= fetch_valid_i;
      if (fetch_valid_i)
      begin
        dec_o <= dec_d;
      end
    end
  end

endmodule

`default_nettype wire

// ==== core/reg_file.sv ====
`default_nettype none

module reg_file
  import w0rm_pkg::*;
(
  input  wire       core_clk,
  input  wire       arst_n_i,
  input  reg_addr_t rd_addr_i,
  input  reg_addr_t rn_addr_i,
  input  reg_addr_t rm_addr_i,
  output data_t     rd_val_o,
  output data_t     rn_val_o,
  output data_t     rm_val_o,
  input  wire       wb_en_i,
  input  reg_addr_t wb_addr_i,
  input  data_t     wb_data_i
);

  data_t regs_q [NUM_REGS];

  // Asynchronous reads
  assign rd_val_o = regs_q[rd_addr_i];
  assign rn_val_o = regs_q[rn_addr_i];
  assign rm_val_o = regs_q[rm_addr_i];

  always_ff @(posedge core_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      for (int i = 0; i < NUM_REGS; i++)
      begin
        regs_q[i] <= '0;
      end
    end
    else if (wb_en_i)
    begin
      regs_q[wb_addr_i] <= wb_data_i;
    end
  end

endmodule

`default_nettype wire

// ==== core/alu_exec.sv ====
`default_nettype none

module alu_exec
  import w0rm_pkg::*;
(
  input  wire      core_clk,
  input  wire      arst_n_i,
  input  wire      dec_valid_i,
  input  decoded_t dec_i,
  output logic     exe_valid_o,
  output exec_t    exe_o
);

  data_t      result;
  logic [4:0] shamt;
  exec_t      exe_d;

  // Only the low 5 bits of rm count for shifts
  assign shamt = dec_i.rm_val[4:0];

  always_comb
  begin
    case (dec_i.op)
      OP_ADD:  result = dec_i.rn_val + dec_i.rm_val;
      OP_SUB:  result = dec_i.rn_val - dec_i.rm_val;
      OP_AND:  result = dec_i.rn_val & dec_i.rm_val;
      OP_OR:   result = dec_i.rn_val | dec_i.rm_val;
      OP_XOR:  result = dec_i.rn_val ^ dec_i.rm_val;
      OP_SHL:  result = dec_i.rn_val << shamt;
      OP_SHR:  result = dec_i.rn_val >> shamt;
      OP_MOVI: result = data_t'(dec_i.imm8);
      default: result = '0;
    endcase
  end

  always_comb
  begin
    exe_d.op         = dec_i.op;
    exe_d.rd         = dec_i.rd;
    exe_d.result     = result;
    exe_d.addr       = dec_i.rn_val;
    exe_d.store_data = dec_i.rd_val;
  end

  always_ff @(posedge core_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      exe_valid_o <= 1'b0;
      exe_o       <= '0;
    end
    else
    begin
      exe_valid_o <= dec_valid_i;
      if (dec_valid_i)
      begin
        exe_o <= exe_d;
      end
    end
  end

endmodule

`default_nettype wire

// ==== mem/data_mem_unit.sv ====
`default_nettype none

module data_mem_unit
  import w0rm_pkg::*;
(
  input  wire       core_clk,
  input  wire       arst_n_i,
  input  wire       exe_valid_i,
  input  exec_t     exe_i,

  // Data port
  output data_t     mem_addr_o,
  output data_t     mem_data_o,
  output logic      mem_read_o,
  output logic      mem_write_o,
  output logic      mem_valid_o,
  input  data_t     mem_data_i,
  input  wire       mem_valid_i,

  // Register write-back
  output logic      wb_en_o,
  output reg_addr_t wb_addr_o,
  output data_t     wb_data_o,
  output logic      retire_o
);

  mem_state_e state_q;
  reg_addr_t  load_rd_q;
  logic       is_mem;
  logic       is_alu;

  assign is_mem = (exe_i.op == OP_LDR) || (exe_i.op == OP_STR);
  assign is_alu = exe_i.op inside {[OP_ADD:OP_MOVI]};

  always_ff @(posedge core_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      state_q     <= IDLE;
      load_rd_q   <= '0;
      mem_addr_o  <= '0;
      mem_data_o  <= '0;
      mem_read_o  <= 1'b0;
      mem_write_o <= 1'b0;
      mem_valid_o <= 1'b0;
      wb_en_o     <= 1'b0;
      wb_addr_o   <= '0;
      wb_data_o   <= '0;
      retire_o    <= 1'b0;
    end
    else
    begin
      wb_en_o  <= 1'b0;
      retire_o <= 1'b0;
      case (state_q)
        IDLE:
        begin
          if (exe_valid_i && is_mem)
          begin
            mem_addr_o  <= exe_i.addr;
            mem_data_o  <= exe_i.store_data;
            mem_read_o  <= (exe_i.op == OP_LDR);
            mem_write_o <= (exe_i.op == OP_STR);
            mem_valid_o <= 1'b1;
            load_rd_q   <= exe_i.rd;
            state_q     <= BUS_WAIT;
          end
          else if (exe_valid_i)
          begin
            // NOP and undefined codes retire without a write
            wb_en_o   <= is_alu;
            wb_addr_o <= exe_i.rd;
            wb_data_o <= exe_i.result;
            retire_o  <= 1'b1;
          end
        end
        BUS_WAIT:
        begin
          if (mem_valid_i)
          begin
            wb_en_o     <= mem_read_o;
            wb_addr_o   <= load_rd_q;
            wb_data_o   <= mem_data_i;
            retire_o    <= 1'b1;
            mem_read_o  <= 1'b0;
            mem_write_o <= 1'b0;
            mem_valid_o <= 1'b0;
            state_q     <= IDLE;
          end
        end
        default:
        begin
          state_q <= IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== hdl/w0rm_core.sv ====
`default_nettype none

module w0rm_core
  import w0rm_pkg::*;
#(
  parameter data_t RESET_PC = '0
)(
  input  wire   core_clk,
  input  wire   arst_n_i,

  // Instruction port
  output data_t inst_addr_o,
  output logic  inst_valid_o,
  input  inst_t inst_data_i,
  input  wire   inst_valid_i,

  // Data port
  output data_t mem_addr_o,
  output data_t mem_data_o,
  output logic  mem_read_o,
  output logic  mem_write_o,
  output logic  mem_valid_o,
  input  data_t mem_data_i,
  input  wire   mem_valid_i
);

  logic      fetch_valid;
  inst_t     fetch_inst;
  logic      dec_valid;
  decoded_t  dec;
  logic      exe_valid;
  exec_t     exe;
  logic      retire;

  reg_addr_t rd_addr;
  reg_addr_t rn_addr;
  reg_addr_t rm_addr;
  data_t     rd_val;
  data_t     rn_val;
  data_t     rm_val;

  logic      wb_en;
  reg_addr_t wb_addr;
  data_t     wb_data;

  inst_fetch #(
    .RESET_PC(RESET_PC)
  ) i_inst_fetch (
    .core_clk      (core_clk),
    .arst_n_i      (arst_n_i),
    .retire_i      (retire),
    .inst_addr_o   (inst_addr_o),
    .inst_valid_o  (inst_valid_o),
    .inst_data_i   (inst_data_i),
    .inst_valid_i  (inst_valid_i),
    .fetch_valid_o (fetch_valid),
    .fetch_inst_o  (fetch_inst)
  );

  instr_decode i_instr_decode (
    .core_clk      (core_clk),
    .arst_n_i      (arst_n_i),
    .fetch_valid_i (fetch_valid),
    .fetch_inst_i  (fetch_inst),
    .rd_addr_o     (rd_addr),
    .rn_addr_o     (rn_addr),
    .rm_addr_o     (rm_addr),
    .rd_val_i      (rd_val),
    .rn_val_i      (rn_val),
    .rm_val_i      (rm_val),
    .dec_valid_o   (dec_valid),
    .dec_o         (dec)
  );

  reg_file i_reg_file (
    .core_clk  (core_clk),
    .arst_n_i  (arst_n_i),
    .rd_addr_i (rd_addr),
    .rn_addr_i (rn_addr),
    .rm_addr_i (rm_addr),
    .rd_val_o  (rd_val),
    .rn_val_o  (rn_val),
    .rm_val_o  (rm_val),
    .wb_en_i   (wb_en),
    .wb_addr_i (wb_addr),
    .wb_data_i (wb_data)
  );

  alu_exec i_alu_exec (
    .core_clk    (core_clk),
    .arst_n_i    (arst_n_i),
    .dec_valid_i (dec_valid),
    .dec_i       (dec),
    .exe_valid_o (exe_valid),
    .exe_o       (exe)
  );

  data_mem_unit i_data_mem_unit (
    .core_clk    (core_clk),
    .arst_n_i    (arst_n_i),
    .exe_valid_i (exe_valid),
    .exe_i       (exe),
    .mem_addr_o  (mem_addr_o),
    .mem_data_o  (mem_data_o),
    .mem_read_o  (mem_read_o),
    .mem_write_o (mem_write_o),
    .mem_valid_o (mem_valid_o),
    .mem_data_i  (mem_data_i),
    .mem_valid_i (mem_valid_i),
    .wb_en_o     (wb_en),
    .wb_addr_o   (wb_addr),
    .wb_data_o   (wb_data),
    .retire_o    (retire)
  );

endmodule

`default_nettype wire

// ==== verification/w0rm_asserts.sv ====
`default_nettype none

module w0rm_asserts
  import w0rm_pkg::*;
(
  input wire   core_clk,
  input wire   arst_n_i,
  input data_t inst_addr_o,
  input wire   inst_valid_o,
  input wire   inst_valid_i,
  input data_t mem_addr_o,
  input data_t mem_data_o,
  input wire   mem_read_o,
  input wire   mem_write_o,
  input wire   mem_valid_o,
  input wire   mem_valid_i
);

  // Fetch request held with a fixed address until accepted
  inst_req_held: assert property (@(posedge core_clk) disable iff (!arst_n_i)
    inst_valid_o && !inst_valid_i |=> inst_valid_o && $stable(inst_addr_o))
    else $error("Instruction request dropped or moved before acceptance");

  mem_req_held: assert property (@(posedge core_clk) disable iff (!arst_n_i)
    mem_valid_o && !mem_valid_i |=> mem_valid_o && $stable(mem_addr_o)
      && $stable(mem_data_o) && $stable(mem_read_o) && $stable(mem_write_o))
    else $error("Data request dropped or changed before acceptance");

  mem_dir_onehot: assert property (@(posedge core_clk) disable iff (!arst_n_i)
    !(mem_read_o && mem_write_o))
    else $error("Read and write strobes high together");

endmodule

bind w0rm_core w0rm_asserts i_w0rm_asserts (
  .core_clk     (core_clk),
  .arst_n_i     (arst_n_i),
  .inst_addr_o  (inst_addr_o),
  .inst_valid_o (inst_valid_o),
  .inst_valid_i (inst_valid_i),
  .mem_addr_o   (mem_addr_o),
  .mem_data_o   (mem_data_o),
  .mem_read_o   (mem_read_o),
  .mem_write_o  (mem_write_o),
  .mem_valid_o  (mem_valid_o),
  .mem_valid_i  (mem_valid_i)
);

`default_nettype wire

// ==== verification/w0rm_tb_model.svh ====
`ifndef W0RM_TB_MODEL_SVH
`define W0RM_TB_MODEL_SVH

// Expected data-port transfer
typedef struct packed {
  logic    is_store;
  opcode_e op;
  data_t   addr;
  data_t   data;
} bus_event_t;

data_t      model_regs [NUM_REGS];
data_t      model_dmem [DMEM_WORDS];
bus_event_t exp_q [$];

task automatic build_program();
  data_t      r;
  logic [3:0] code;
  for (int i = 0; i < NUM_INSTR; i++)
  begin
    r = next_rand();
    // Stores a quarter of the time, literals an eighth, else any code
    case (r[31:29])
      3'd0, 3'd1: code = OP_STR;
      3'd2:       code = OP_MOVI;
      default:    code = r[15:12];
    endcase
    imem[i] = {code, r[11:0]};
  end
  for (int i = 0; i < DMEM_WORDS; i++)
  begin
    r             = next_rand();
    dmem[i]       = r;
    model_dmem[i] = r;
  end
  for (int i = 0; i < NUM_REGS; i++)
  begin
    model_regs[i] = '0;
  end
endtask

// Runs one instruction on the model state and queues any bus transfer
task automatic model_execute(input inst_t inst, output opcode_e op);
  reg_addr_t  rd;
  data_t      rn_v;
  data_t      rm_v;
  bus_event_t ev;
  if (inst[15:12] > 4'd10)
  begin
    op = OP_NOP;
  end
  else
  begin
    op = opcode_e'(inst[15:12]);
  end
  rd      = inst[11:8];
  rn_v    = model_regs[inst[7:4]];
  rm_v    = model_regs[inst[3:0]];
  ev.op   = op;
  ev.addr = rn_v;
  case (op)
    OP_ADD:  model_regs[rd] = rn_v + rm_v;
    OP_SUB:  model_regs[rd] = rn_v - rm_v;
    OP_AND:  model_regs[rd] = rn_v & rm_v;
    OP_OR:   model_regs[rd] = rn_v | rm_v;
    OP_XOR:  model_regs[rd] = rn_v ^ rm_v;
    OP_SHL:  model_regs[rd] = rn_v << rm_v[4:0];
    OP_SHR:  model_regs[rd] = rn_v >> rm_v[4:0];
    OP_MOVI: model_regs[rd] = {24'd0, inst[7:0]};
    OP_LDR:
    begin
      ev.is_store = 1'b0;
      ev.data     = model_dmem[mem_index(rn_v)];
      exp_q.push_back(ev);
      model_regs[rd] = ev.data;
    end
    OP_STR:
    begin
      ev.is_store = 1'b1;
      ev.data     = model_regs[rd];
      exp_q.push_back(ev);
      model_dmem[mem_index(rn_v)] = ev.data;
    end
    default:
    begin
    end
  endcase
endtask

`endif

// ==== verification/w0rm_tb.sv ====
`default_nettype none

module w0rm_tb
  import w0rm_pkg::*;
();

  localparam int    CLK_PERIOD    = 4;
  localparam int    RESET_CYCLES  = 5;
  localparam int    NUM_INSTR     = 200;
  localparam int    DMEM_WORDS    = 64;
  localparam data_t RESET_PC      = '0;
  localparam int    WATCHDOG_TIME = NUM_INSTR * 20 * CLK_PERIOD;

  logic  core_clk;
  logic  arst_n_i;
  data_t inst_addr_o;
  logic  inst_valid_o;
  inst_t inst_data_i;
  logic  inst_valid_i;
  data_t mem_addr_o;
  data_t mem_data_o;
  logic  mem_read_o;
  logic  mem_write_o;
  logic  mem_valid_o;
  data_t mem_data_i;
  logic  mem_valid_i;

  inst_t   imem [NUM_INSTR];
  data_t   dmem [DMEM_WORDS];
  data_t   rng_state;
  int      fetch_count;
  opcode_e prev_op;

  w0rm_core #(
    .RESET_PC(RESET_PC)
  ) i_w0rm_core (
    .core_clk     (core_clk),
    .arst_n_i     (arst_n_i),
    .inst_addr_o  (inst_addr_o),
    .inst_valid_o (inst_valid_o),
    .inst_data_i  (inst_data_i),
    .inst_valid_i (inst_valid_i),
    .mem_addr_o   (mem_addr_o),
    .mem_data_o   (mem_data_o),
    .mem_read_o   (mem_read_o),
    .mem_write_o  (mem_write_o),
    .mem_valid_o  (mem_valid_o),
    .mem_data_i   (mem_data_i),
    .mem_valid_i  (mem_valid_i)
  );

  function automatic data_t xorshift32(input data_t x);
    data_t y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic data_t next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // Word index into a data memory that aliases every 256 bytes
  function automatic int unsigned mem_index(input data_t addr);
    return int'(addr[7:2]);
  endfunction

  `include "w0rm_tb_model.svh"

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic check_inst_addr(input opcode_e op, input data_t exp, input data_t act);
    if (act !== exp)
    begin
      report_failure($sformatf("CHECK FAILED: fetch address after %s expected %h actual %h",
                               op.name(), exp, act));
    end
  endtask

  task automatic check_store(input opcode_e op, input data_t exp_addr, input data_t exp_data,
                             input data_t act_addr, input data_t act_data);
    if (act_addr !== exp_addr)
    begin
      report_failure($sformatf("CHECK FAILED: %s address expected %h actual %h",
                               op.name(), exp_addr, act_addr));
    end
    else if (act_data !== exp_data)
    begin
      report_failure($sformatf("CHECK FAILED: %s data expected %h actual %h",
                               op.name(), exp_data, act_data));
    end
  endtask

  task automatic check_load_addr(input opcode_e op, input data_t exp, input data_t act);
    if (act !== exp)
    begin
      report_failure($sformatf("CHECK FAILED: %s address expected %h actual %h",
                               op.name(), exp, act));
    end
  endtask

  task automatic wait_cycles(input int unsigned n);
    repeat (n)
    begin
      @(posedge core_clk);
      #1;
    end
  endtask

  task automatic finish_run();
    if (exp_q.size() != 0)
    begin
      report_failure($sformatf("%0d expected data-port transfers never happened",
                               exp_q.size()));
    end
    else
    begin
      $display("TEST OK");
      $finish;
    end
  endtask

  task automatic serve_fetch();
    data_t exp_pc;
    exp_pc = RESET_PC + data_t'(2 * fetch_count);
    check_inst_addr(prev_op, exp_pc, inst_addr_o);
    // Request past the program means every instruction retired
    if (fetch_count == NUM_INSTR)
    begin
      finish_run();
    end
    else
    begin
      model_execute(imem[fetch_count], prev_op);
      wait_cycles(next_rand() % 4);
      inst_data_i  = imem[fetch_count];
      inst_valid_i = 1'b1;
      fetch_count++;
      wait_cycles(1);
      inst_valid_i = 1'b0;
    end
  endtask

  task automatic serve_data();
    bus_event_t ev;
    if (exp_q.size() == 0)
    begin
      report_failure("Data-port transfer issued with no load or store in flight");
    end
    else
    begin
      ev = exp_q.pop_front();
      if (ev.is_store !== mem_write_o || ev.is_store === mem_read_o)
      begin
        report_failure("Data-port transfer has the wrong direction");
      end
      else
      begin
        if (ev.is_store)
        begin
          check_store(ev.op, ev.addr, ev.data, mem_addr_o, mem_data_o);
          dmem[mem_index(mem_addr_o)] = mem_data_o;
        end
        else
        begin
          check_load_addr(ev.op, ev.addr, mem_addr_o);
          mem_data_i = dmem[mem_index(mem_addr_o)];
        end
        wait_cycles(next_rand() % 4);
        mem_valid_i = 1'b1;
        wait_cycles(1);
        mem_valid_i = 1'b0;
      end
    end
  endtask

  initial
  begin
    core_clk = 1'b0;
    forever #(CLK_PERIOD / 2) core_clk = ~core_clk;
  end

  initial
  begin
    arst_n_i     = 1'b0;
    inst_data_i  = '0;
    inst_valid_i = 1'b0;
    mem_data_i   = '0;
    mem_valid_i  = 1'b0;
    rng_state    = data_t'(48);
    fetch_count  = 0;
    prev_op      = OP_NOP;
    build_program();
    repeat (RESET_CYCLES)
    begin
      @(posedge core_clk);
      #1;
      if (inst_valid_o !== 1'b0 || mem_valid_o !== 1'b0)
      begin
        report_failure("A port request was high during reset");
      end
    end
    arst_n_i = 1'b1;
  end

  // Instruction memory
  initial
  begin
    wait (arst_n_i === 1'b1);
    forever
    begin
      @(posedge core_clk);
      #1;
      if (inst_valid_o)
      begin
        serve_fetch();
      end
    end
  end

  // Data memory
  initial
  begin
    wait (arst_n_i === 1'b1);
    forever
    begin
      @(posedge core_clk);
      #1;
      if (mem_valid_o)
      begin
        serve_data();
      end
    end
  end

  initial
  begin
    #(WATCHDOG_TIME);
    report_failure($sformatf("The core stalled: %0d of %0d instructions fetched in time",
                             fetch_count, NUM_INSTR));
  end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+verification
common/w0rm_pkg.sv
fetch/inst_fetch.sv
core/instr_decode.sv
core/reg_file.sv
core/alu_exec.sv
mem/data_mem_unit.sv
hdl/w0rm_core.sv
verification/w0rm_asserts.sv
verification/w0rm_tb.sv

// ==== Bender.yml ====
package:
  name: w0rm_core

sources:
  - common/w0rm_pkg.sv
  - fetch/inst_fetch.sv
  - core/instr_decode.sv
  - core/reg_file.sv
  - core/alu_exec.sv
  - mem/data_mem_unit.sv
  - hdl/w0rm_core.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/w0rm_asserts.sv
      - verification/w0rm_tb.sv
